// File: hw/spy_cfg.svh
// Spy port configuration: serial timing, FIFO depth, register count and ID value
`ifndef SPY_CFG_SVH
`define SPY_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Serial line

// Clock cycles per RS-232 bit
`define SPY_CLKS_PER_BIT 8

//////////////////////////////////////////////////////////////////////
// Controller and target

// Transmit FIFO entries, also the controller's starting credit count
`define SPY_TX_DEPTH 4

// Registers on the target bus
`define SPY_NUM_REGS 32

// Value returned by register 0
`define SPY_ID 16'hC0DE

`endif

// File: hw/spy_pkg.sv
// Spy port types: command byte views, byte stream and register bus request
`default_nettype none

package spy_pkg;

   // Data load commands, opcode 3..6 carries one nibble
   typedef struct packed {
      logic [3:0] op;
      logic [3:0] nib;
   } spy_nib_t;

   // Register commands, opcode 8..B carries a 5-bit address
   typedef struct packed {
      logic [2:0] op_hi;
      logic [4:0] addr;
   } spy_adr_t;

   // One command byte, the opcode picks the view
   typedef union packed {
      spy_nib_t nib;
      spy_adr_t adr;
   } spy_cmd_u;

   // Byte stream between UARTs and controller
   typedef struct packed {
      logic     valid;
      spy_cmd_u data;
   } spy_byte_t;

   // Request to the target register file
   typedef struct packed {
      logic        rd;
      logic        wr;
      logic [4:0]  addr;
      logic [15:0] wdata;
   } spy_bus_req_t;

endpackage

`default_nettype wire

// File: hw/spy_port.sv
// Spy controller decoding host commands, driving the register bus and building read replies
`timescale 1ns/10ps
`default_nettype none
`include "spy_cfg.svh"

module spy_port (
   input  logic                  clk,
   input  logic                  reset,
   input  spy_pkg::spy_byte_t    rx_byte,
   output spy_pkg::spy_byte_t    tx_byte,
   input  logic                  credit,
   output spy_pkg::spy_bus_req_t bus_req,
   input  logic [15:0]           rd_data
);

   import spy_pkg::*;

   localparam int DEPTH = `SPY_TX_DEPTH;
   localparam int NW    = $clog2(DEPTH + 1);

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_RREQ  = 3'd1;
   localparam logic [2:0] S_RCAP  = 3'd2;
   localparam logic [2:0] S_SEND0 = 3'd3;
   localparam logic [2:0] S_SEND1 = 3'd4;
   localparam logic [2:0] S_SEND2 = 3'd5;
   localparam logic [2:0] S_SEND3 = 3'd6;

   spy_cmd_u      cmd;
   logic [2:0]    state;
   logic [15:0]   data_q;
   logic [15:0]   resp_q;
   logic [NW-1:0] credits;
   logic          accept;
   logic          is_read;
   logic          is_write;
   logic          send_ok;
   logic [3:0]    send_op;
   logic [3:0]    send_nib;
   logic          bus_rd;
   logic          bus_wr;
   logic [4:0]    bus_addr;
   logic [15:0]   bus_wdata;

   assign cmd      = rx_byte.data;
   // Bytes outside idle are dropped
   assign accept   = rx_byte.valid && state == S_IDLE;
   assign is_read  = cmd.adr.op_hi == 3'b100;
   assign is_write = cmd.adr.op_hi == 3'b101;

   //////////////////////////////////////////////////////////////////////
   // Command decode

   // Nibbles load the data register most significant first
   always_ff @(posedge clk) begin
      if (reset) begin
         data_q <= '0;
      end else if (accept) begin
         case (cmd.nib.op)
            4'h3:    data_q[15:12] <= cmd.nib.nib;
            4'h4:    data_q[11:8]  <= cmd.nib.nib;
            4'h5:    data_q[7:4]   <= cmd.nib.nib;
            4'h6:    data_q[3:0]   <= cmd.nib.nib;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         bus_rd <= 1'b0;
         bus_wr <= 1'b0;
      end else begin
         bus_rd <= accept && is_read;
         bus_wr <= accept && is_write;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         bus_addr  <= cmd.adr.addr;
         bus_wdata <= data_q;
      end
   end

   assign bus_req = {bus_rd, bus_wr, bus_addr, bus_wdata};

   //////////////////////////////////////////////////////////////////////
   // Read sequencer and reply

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE:  if (accept && is_read) state <= S_RREQ;
            S_RREQ:  state <= S_RCAP;
            S_RCAP:  state <= S_SEND0;
            S_SEND3: if (send_ok) state <= S_IDLE;
            default: if (send_ok) state <= state + 3'd1;
         endcase
      end
   end

   // Register value arrives the cycle after the request
   always_ff @(posedge clk) begin
      if (state == S_RCAP)
         resp_q <= rd_data;
   end

   always_comb begin
      case (state)
         S_SEND0: send_nib = resp_q[15:12];
         S_SEND1: send_nib = resp_q[11:8];
         S_SEND2: send_nib = resp_q[7:4];
         default: send_nib = resp_q[3:0];
      endcase
   end

   // Reply tags run 3, 4, 5, 6
   assign send_op = 4'(state - S_SEND0) + 4'h3;
   assign send_ok = state >= S_SEND0 && credits != '0;
   assign tx_byte = {send_ok, send_op, send_nib};

   always_ff @(posedge clk) begin
      if (reset)
         credits <= NW'(DEPTH);
      else
         credits <= credits - NW'(send_ok) + NW'(credit);
   end

   assert property (@(posedge clk) disable iff (reset) credits <= NW'(DEPTH))
      else $error("spy_port: more credits returned than bytes sent");

endmodule

`default_nettype wire

// File: hw/spy_regfile.sv
// Spy target register file: 32 x 16 registers, register 0 reads the ID constant
`timescale 1ns/10ps
`default_nettype none
`include "spy_cfg.svh"

module spy_regfile (
   input  logic                  clk,
   input  logic                  reset,
   input  spy_pkg::spy_bus_req_t bus_req,
   output logic [15:0]           rd_data
);

   // Register 0 has no storage
   logic [15:0] regs [1:`SPY_NUM_REGS-1];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < `SPY_NUM_REGS; i++)
            regs[i] <= '0;
         rd_data <= '0;
      end else begin
         if (bus_req.wr && bus_req.addr != 5'd0)
            regs[bus_req.addr] <= bus_req.wdata;
         if (bus_req.rd)
            rd_data <= (bus_req.addr == 5'd0) ? `SPY_ID : regs[bus_req.addr];
      end
   end

   assert property (@(posedge clk) disable iff (reset) !(bus_req.rd && bus_req.wr))
      else $error("spy_regfile: read and write in the same cycle");

endmodule

`default_nettype wire

// File: hw/spy_top.sv
// Spy port top level: RS-232 receiver, controller, transmitter and target registers
`timescale 1ns/10ps
`default_nettype none

module spy_top (
   input  logic clk,
   input  logic reset,
   input  logic rs232_rxd,
   output logic rs232_txd
);

   import spy_pkg::*;

   spy_byte_t    rx_byte;
   spy_byte_t    tx_byte;
   spy_bus_req_t bus_req;
   logic         credit;
   logic [15:0]  rd_data;

   spy_uart_rx i_uart_rx (
      .clk     (clk),
      .reset   (reset),
      .rxd     (rs232_rxd),
      .rx_byte (rx_byte)
   );

   spy_port i_port (
      .clk     (clk),
      .reset   (reset),
      .rx_byte (rx_byte),
      .tx_byte (tx_byte),
      .credit  (credit),
      .bus_req (bus_req),
      .rd_data (rd_data)
   );

   spy_uart_tx i_uart_tx (
      .clk     (clk),
      .reset   (reset),
      .tx_byte (tx_byte),
      .credit  (credit),
      .txd     (rs232_txd)
   );

   spy_regfile i_regfile (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// File: hw/spy_uart_rx.sv
// Spy UART receiver: samples 8N1 frames at mid-bit and emits one byte per frame
`timescale 1ns/10ps
`default_nettype none
`include "spy_cfg.svh"

module spy_uart_rx (
   input  logic               clk,
   input  logic               reset,
   input  logic               rxd,
   output spy_pkg::spy_byte_t rx_byte
);

   localparam int CW = $clog2(`SPY_CLKS_PER_BIT);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_START = 2'd1;
   localparam logic [1:0] S_DATA  = 2'd2;
   localparam logic [1:0] S_STOP  = 2'd3;

   logic          rxd_meta;
   logic          rxd_s;
   logic [1:0]    state;
   logic [CW-1:0] cnt;
   logic [2:0]    bit_idx;
   logic [7:0]    shreg;
   logic          valid_q;
   logic          bit_end;
   logic          mid_start;

   assign bit_end   = cnt == CW'(`SPY_CLKS_PER_BIT - 1);
   assign mid_start = cnt == CW'(`SPY_CLKS_PER_BIT / 2 - 1);

   // Line idles high
   always_ff @(posedge clk) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_s    <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_s    <= rxd_meta;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Frame sequencer

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= S_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         cnt     <= cnt + CW'(1);
         case (state)
            S_IDLE: begin
               cnt <= '0;
               if (!rxd_s)
                  state <= S_START;
            end
            S_START: begin
               // A glitch shorter than half a bit is no start bit
               if (mid_start) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rxd_s ? S_IDLE : S_DATA;
               end
            end
            S_DATA: begin
               if (bit_end) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7)
                     state <= S_STOP;
               end
            end
            default: begin
               // Bad stop bit drops the frame
               if (bit_end) begin
                  valid_q <= rxd_s;
                  state   <= S_IDLE;
               end
            end
         endcase
      end
   end

   // LSB first
   always_ff @(posedge clk) begin
      if (state == S_DATA && bit_end)
         shreg <= {rxd_s, shreg[7:1]};
   end

   assign rx_byte = {valid_q, shreg};

endmodule

`default_nettype wire

// File: hw/spy_uart_tx.sv
// Spy UART transmitter: byte FIFO feeding an 8N1 serializer, one credit per pop
`timescale 1ns/10ps
`default_nettype none
`include "spy_cfg.svh"

module spy_uart_tx (
   input  logic               clk,
   input  logic               reset,
   input  spy_pkg::spy_byte_t tx_byte,
   output logic               credit,
   output logic               txd
);

   import spy_pkg::*;

   localparam int DEPTH = `SPY_TX_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int NW    = $clog2(DEPTH + 1);
   localparam int CW    = $clog2(`SPY_CLKS_PER_BIT);

   spy_cmd_u      mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [NW-1:0] count;
   logic [9:0]    shreg;
   logic [CW-1:0] cnt;
   logic [3:0]    bit_idx;
   logic          busy;
   logic          pop;
   logic          frame_end;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
      return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + PW'(1);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // FIFO

   // Next frame is loaded on the last cycle of the current one
   assign frame_end = busy && bit_idx == 4'd9 && cnt == CW'(`SPY_CLKS_PER_BIT - 1);
   assign pop       = (!busy || frame_end) && count != '0;

   always_ff @(posedge clk) begin
      if (tx_byte.valid)
         mem[wr_ptr] <= tx_byte.data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (tx_byte.valid)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         count <= count + NW'(tx_byte.valid) - NW'(pop);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Serializer

   always_ff @(posedge clk) begin
      if (reset) begin
         busy    <= 1'b0;
         shreg   <= '1;
         cnt     <= '0;
         bit_idx <= '0;
         credit  <= 1'b0;
      end else begin
         credit <= pop;
         if (pop) begin
            // Stop, data, start
            shreg   <= {1'b1, mem[rd_ptr], 1'b0};
            busy    <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
         end else if (busy) begin
            if (cnt == CW'(`SPY_CLKS_PER_BIT - 1)) begin
               cnt     <= '0;
               shreg   <= {1'b1, shreg[9:1]};
               bit_idx <= bit_idx + 4'd1;
               if (bit_idx == 4'd9)
                  busy <= 1'b0;
            end else begin
               cnt <= cnt + CW'(1);
            end
         end
      end
   end

   assign txd = shreg[0];

   // Controller credits must keep the FIFO from overflowing
   assert property (@(posedge clk) disable iff (reset)
      tx_byte.valid |-> (count != NW'(DEPTH) || pop))
      else $error("spy_uart_tx: push into full FIFO");

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the spy port testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f sim.f --top-module spy_tb -Mdir build/obj_dir -o Vspy_tb

./build/obj_dir/Vspy_tb | tee build/sim.log

if grep -q "Simulation completed successfully" build/sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

// File: sim.f
+incdir+hw
hw/spy_pkg.sv
hw/spy_uart_rx.sv
hw/spy_uart_tx.sv
hw/spy_port.sv
hw/spy_regfile.sv
hw/spy_top.sv
tests/spy_tb.sv

// File: tests/spy_tb.sv
// Spy port testbench driving RS-232 commands, decoding the replies and checking a register model
`timescale 1ns/10ps
`default_nettype none
`include "spy_cfg.svh"

module spy_tb;

   localparam int CLKS     = `SPY_CLKS_PER_BIT;
   localparam int FRAME    = 10 * CLKS;
   localparam int NUM_RAND = 16;
   localparam int NUM_IGN  = 8;
   // Line bytes per test counting 5 for each read and each write
   localparam int TEST_BYTES  = 2 + 31 * 5 + 15 + NUM_RAND * 10 + NUM_IGN * 8 + 25;
   localparam int WATCHDOG_NS = TEST_BYTES * FRAME * 4 * 2;
   localparam logic [3:0] IGN_OPS [NUM_IGN] = '{4'h0, 4'h1, 4'h2, 4'h7, 4'hC, 4'hD, 4'hE, 4'hF};

   logic        clk;
   logic        reset;
   logic        rs232_rxd;
   logic        rs232_txd;
   logic [15:0] ref_regs [32];
   logic [15:0] ref_data;

   spy_top i_dut (
      .clk       (clk),
      .reset     (reset),
      .rs232_rxd (rs232_rxd),
      .rs232_txd (rs232_txd)
   );

   always #2 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reporting

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "spy_tb stopped at the first error");
   endtask

   task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
      assert (got === exp)
      else fail_run($sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                              $time, what, got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Serial driver and monitor

   // 8N1 frame sent LSB first
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         rs232_rxd = frame[i];
         repeat (CLKS - 1) @(negedge clk);
      end
   endtask

   task automatic recv_byte(input int max_cycles, output logic got, output logic [7:0] b);
      int i;
      got = 1'b0;
      b   = '0;
      i   = 0;
      while (!got && i < max_cycles) begin
         @(negedge clk);
         got = !rs232_txd;
         i++;
      end
      if (got) begin
         // Move to the middle of the start bit
         repeat (CLKS / 2) @(negedge clk);
         assert (!rs232_txd) else fail_run("Start bit on rs232_txd lasted less than half a bit");
         for (i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            b[i] = rs232_txd;
         end
         repeat (CLKS) @(negedge clk);
         assert (rs232_txd) else fail_run("Stop bit on rs232_txd was low");
      end
   endtask

   task automatic expect_quiet(input string what);
      logic       got;
      logic [7:0] b;
      recv_byte(2 * FRAME, got, b);
      assert (!got) else fail_run($sformatf("Unexpected byte %h on rs232_txd %s", b, what));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Command tasks and reference model

   task automatic load_nibble(input logic [3:0] op, input logic [3:0] nib);
      send_byte({op, nib});
      case (op)
         4'h3: ref_data[15:12] = nib;
         4'h4: ref_data[11:8]  = nib;
         4'h5: ref_data[7:4]   = nib;
         4'h6: ref_data[3:0]   = nib;
         default: ;
      endcase
   endtask

   // Register 0 keeps the ID
   task automatic write_cmd(input logic [4:0] addr);
      send_byte({3'b101, addr});
      if (addr != 5'd0)
         ref_regs[addr] = ref_data;
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [15:0] value);
      load_nibble(4'h3, value[15:12]);
      load_nibble(4'h4, value[11:8]);
      load_nibble(4'h5, value[7:4]);
      load_nibble(4'h6, value[3:0]);
      write_cmd(addr);
   endtask

   task automatic read_reg(input logic [4:0] addr, output logic [15:0] value);
      logic [7:0] resp [4];
      logic       got [4];
      fork
         send_byte({3'b100, addr});
         begin
            recv_byte(3 * FRAME, got[0], resp[0]);
            for (int k = 1; k < 4; k++)
               recv_byte(2 * FRAME, got[k], resp[k]);
         end
      join
      value = '0;
      for (int k = 0; k < 4; k++) begin
         assert (got[k])
         else fail_run($sformatf("No reply byte %0d for a read of register %0d", k, addr));
         check_value(16'(resp[k][7:4]), 16'(k + 3), $sformatf("reply byte %0d tag", k));
         value = {value[11:0], resp[k][3:0]};
      end
   endtask

   task automatic check_reg(input logic [4:0] addr);
      logic [15:0] value;
      read_reg(addr, value);
      check_value(value, ref_regs[addr], $sformatf("register %0d", addr));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic test_reset_idle();
      logic [15:0] value;
      expect_quiet("after reset");
      for (int a = 1; a < 32; a++) begin
         read_reg(5'(a), value);
         check_value(value, 16'h0, $sformatf("register %0d after reset", a));
      end
   endtask

   task automatic test_id_reg();
      logic [15:0] value;
      read_reg(5'd0, value);
      check_value(value, `SPY_ID, "ID register");
      write_reg(5'd0, 16'h5A5A);
      read_reg(5'd0, value);
      check_value(value, `SPY_ID, "ID register after write");
   endtask

   // Even steps hit 1..15 through opcode A, odd steps 16..31 through B
   task automatic test_random_rw();
      logic [4:0] addr [NUM_RAND];
      for (int i = 0; i < NUM_RAND; i++) begin
         addr[i] = (i % 2 == 1) ? 5'($urandom_range(31, 16)) : 5'($urandom_range(15, 1));
         write_reg(addr[i], 16'($urandom));
      end
      for (int i = 0; i < NUM_RAND; i++)
         check_reg(addr[i]);
   endtask

   task automatic test_ignored();
      logic [7:0] cmd;
      for (int i = 0; i < NUM_IGN; i++) begin
         cmd = {IGN_OPS[i], 4'($urandom)};
         send_byte(cmd);
         expect_quiet($sformatf("after ignored command %h", cmd));
         check_reg(cmd[4:0]);
      end
   endtask

   task automatic test_partial_load();
      write_reg(5'd7, 16'h1234);
      load_nibble(4'h5, 4'hA);
      load_nibble(4'h6, 4'hB);
      write_cmd(5'd20);
      check_reg(5'd20);
      check_reg(5'd7);
      load_nibble(4'h3, 4'hF);
      write_cmd(5'd9);
      check_reg(5'd9);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Run control

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      rs232_rxd = 1'b1;
      ref_data  = '0;
      for (int i = 0; i < 32; i++)
         ref_regs[i] = '0;
      ref_regs[0] = `SPY_ID;
      void'($urandom(60));
      repeat (2) @(negedge clk);
      reset = 1'b0;

      test_reset_idle();
      test_id_reg();
      test_random_rw();
      test_ignored();
      test_partial_load();

      $display("Simulation completed successfully");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      fail_run($sformatf("Watchdog expired after %0d ns, the DUT stopped responding",
                         WATCHDOG_NS));
   end

endmodule

`default_nettype wire
